//--- Bender.yml
package:
  name: addsub_stage

sources:
  # RTL, in compile order
  - include_dirs:
      - verilog
    files:
      - verilog/addsub_pkg.sv
      - verilog/adder_cla_4bit.sv
      - verilog/operand_lookahead.sv
      - verilog/saturate_unit.sv
      - verilog/addsub_16bit.sv
      - verilog/addsub_stage.sv

  # testbench, top module tb_addsub_stage
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_addsub_stage.sv

//--- filelist.f
+incdir+verilog
verilog/addsub_pkg.sv
verilog/adder_cla_4bit.sv
verilog/operand_lookahead.sv
verilog/saturate_unit.sv
verilog/addsub_16bit.sv
verilog/addsub_stage.sv
testbench/tb_addsub_stage.sv

//--- testbench/tb_addsub_stage.sv
/*
 * testbench for the registered saturating adder/subtractor
 * reset, whole-word, saturation, packed-lane and mode-switch tests
 * xorshift operands mixed with corner values, behavioral reference model
 * one-cycle expected pipe, concurrent output checks, report and watchdog
 */
`timescale 1ns/100ps

module tb_addsub_stage;
    import addsub_pkg::*;

    localparam int CLK_PERIOD   = 100;  // ns
    localparam int RESET_CYCLES = 8;
    localparam int NUM_OPS      = 64;   // operations per test
    localparam int NUM_TESTS    = 5;
    localparam int DRAIN_CYCLES = 3;    // last op reaches the checks
    localparam int TIMEOUT_NS   =
        (RESET_CYCLES + NUM_TESTS * (NUM_OPS + DRAIN_CYCLES) + 40) * CLK_PERIOD;

    logic  clk;
    logic  rst_n;
    logic  padd;
    logic  sub;
    word_t a;
    word_t b;
    word_t s;
    logic  cout;
    logic  sat;

    // expected values presented together with the inputs
    word_t exp_in_s;
    logic  exp_in_cout;
    logic  exp_in_sat;
    logic  exp_in_valid;
    int    exp_in_test;
    // same values one clock later to line up with the registered outputs
    word_t exp_out_s;
    logic  exp_out_cout;
    logic  exp_out_sat;
    logic  exp_out_valid;
    int    exp_out_test;

    logic        check_en;      // outputs are known from here on
    logic [31:0] rng_state;     // xorshift state
    int          mismatches;
    int          tests_ok;
    int          tests_bad;
    int          test_errs[NUM_TESTS];
    string       test_names[NUM_TESTS] = '{"reset", "whole_nominal", "whole_saturate",
                                           "packed_lanes", "mode_switch"};

    addsub_stage addsub_stage_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .padd  (padd),
        .sub   (sub),
        .a     (a),
        .b     (b),
        .s     (s),
        .cout  (cout),
        .sat   (sat)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // one register stage of expected values cleared like the outputs
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_out_s     <= '0;
            exp_out_cout  <= 1'b0;
            exp_out_sat   <= 1'b0;
            exp_out_valid <= 1'b1;  // zero outputs are checked during reset too
            exp_out_test  <= 0;
        end else begin
            exp_out_s     <= exp_in_s;
            exp_out_cout  <= exp_in_cout;
            exp_out_sat   <= exp_in_sat;
            exp_out_valid <= exp_in_valid;
            exp_out_test  <= exp_in_test;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // {cout, sat, s} from signed arithmetic and clamping
    function automatic logic [17:0] expected_result(input logic p, input logic sub_op,
                                                    input word_t av, input word_t bv);
        word_t       res;
        logic        flag;
        logic        cy;
        logic [16:0] wide;
        int          opa;
        int          opb;
        int          sum;
        res  = '0;
        flag = 1'b0;
        cy   = 1'b0;
        if (!p) begin
            opa  = $signed(av);
            opb  = $signed(bv);
            sum  = sub_op ? opa - opb : opa + opb;
            wide = {1'b0, av} + {1'b0, (sub_op ? ~bv : bv)} + 17'(sub_op);
            cy   = wide[16];                // 17th bit of a + b_cond + sub
            if (sum > 32767) begin
                res  = 16'h7FFF;
                flag = 1'b1;
            end else if (sum < -32768) begin
                res  = 16'h8000;
                flag = 1'b1;
            end else begin
                res = sum[15:0];
            end
        end else begin
            for (int l = 0; l < 4; l++) begin
                opa = $signed(av[l*4 +: 4]);
                opb = $signed(bv[l*4 +: 4]);
                sum = sub_op ? opa - opb : opa + opb;
                if (sum > 7) begin
                    res[l*4 +: 4] = 4'h7;   // lane clamps on its own
                    flag = 1'b1;
                end else if (sum < -8) begin
                    res[l*4 +: 4] = 4'h8;
                    flag = 1'b1;
                end else begin
                    res[l*4 +: 4] = sum[3:0];
                end
            end
        end
        return {cy, flag, res};
    endfunction

    task automatic draw_word(output word_t w);
        rng_state = xorshift32(rng_state);
        w = rng_state[15:0] ^ rng_state[31:16];
    endtask

    // present one operation on the next rising edge
    task automatic apply_op(input int tidx, input logic p, input logic sub_op,
                            input word_t av, input word_t bv);
        logic [17:0] expv;
        expv = expected_result(p, sub_op, av, bv);
        @(posedge clk);
        padd         <= p;
        sub          <= sub_op;
        a            <= av;
        b            <= bv;
        exp_in_s     <= expv[15:0];
        exp_in_sat   <= expv[16];
        exp_in_cout  <= expv[17];
        exp_in_valid <= 1'b1;
        exp_in_test  <= tidx;
    endtask

    task automatic drain_pipe();
        @(posedge clk);
        exp_in_valid <= 1'b0;   // later results are not checked
        repeat (DRAIN_CYCLES - 1) @(posedge clk);
    endtask

    task automatic finish_test(input int tidx, input int ops);
        $display("test %-15s done: %0d ops, %0d errors", test_names[tidx], ops,
                 test_errs[tidx]);
        if (test_errs[tidx] == 0)
            tests_ok++;
        else
            tests_bad++;
    endtask

    task automatic report_mismatch(input string what, input int tidx,
                                   input word_t expv, input word_t actv);
        mismatches++;
        test_errs[tidx]++;
        $display("FAIL %s %s: expected %h actual %h", test_names[tidx], what, expv, actv);
    endtask

    task automatic run_tests();
        word_t ra;
        word_t rb;
        logic  sub_op;
        // whole-word ops on 15-bit operands that cannot overflow
        for (int i = 0; i < NUM_OPS; i++) begin
            draw_word(ra);
            draw_word(rb);
            ra = {ra[14], ra[14:0]};
            rb = {rb[14], rb[14:0]};
            if (i == 0) begin
                ra = 16'hFFFF;  // -1 + 1 wraps to 0 with carry
                rb = 16'h0001;
            end
            apply_op(1, 1'b0, i[0], ra, rb);
        end
        drain_pipe();
        finish_test(1, NUM_OPS);
        // whole-word pairs that overflow in each direction
        for (int i = 0; i < NUM_OPS; i++) begin
            draw_word(ra);
            draw_word(rb);
            case (i % 4)
                0: {ra, rb} = {2'b01, ra[13:0], 2'b01, rb[13:0]};        // pos + pos
                1: {ra, rb} = {2'b10, ra[13:0], 2'b10, rb[13:0]};        // neg + neg
                2: {ra, rb} = {2'b01, ra[13:0], 2'b10, rb[13:0]};        // pos - neg
                default: {ra, rb} = {2'b10, ra[13:0], 2'b01, rb[13:0]};  // neg - pos
            endcase
            case (i)
                0: {ra, rb} = {16'h7FFF, 16'h0001};
                1: {ra, rb} = {16'h8000, 16'hFFFF};
                2: {ra, rb} = {16'h0000, 16'h8000};    // 0 - min
                3: {ra, rb} = {16'h8000, 16'h0001};
                default: ;
            endcase
            apply_op(2, 1'b0, i[1], ra, rb);
        end
        drain_pipe();
        finish_test(2, NUM_OPS);
        // random packed lanes after a few all-lane corners
        for (int i = 0; i < NUM_OPS; i++) begin
            draw_word(ra);
            draw_word(rb);
            sub_op = rng_state[20];
            case (i)
                0: {ra, rb, sub_op} = {16'h7777, 16'h1111, 1'b0};  // every lane +max
                1: {ra, rb, sub_op} = {16'h8888, 16'h1111, 1'b1};  // every lane -min
                2: {ra, rb, sub_op} = {16'h0000, 16'h8888, 1'b1};  // 0 - (-8)
                3: {ra, rb, sub_op} = {16'h7878, 16'h7878, 1'b0};  // mixed clamps
                default: ;
            endcase
            apply_op(3, 1'b1, sub_op, ra, rb);
        end
        drain_pipe();
        finish_test(3, NUM_OPS);
        // padd flips on every edge, sub every second edge
        for (int i = 0; i < NUM_OPS; i++) begin
            draw_word(ra);
            draw_word(rb);
            if (i % 8 == 4) begin
                ra = 16'h7FFF;  // whole-word add that clamps to max
                rb = 16'h7FFF;
            end
            apply_op(4, i[0], i[1], ra, rb);
        end
        drain_pipe();
        finish_test(4, NUM_OPS);
    endtask

    // result checks one clock behind the presented operation
    chk_s: assert property (@(posedge clk) (check_en && exp_out_valid) |-> (s == exp_out_s))
        else report_mismatch("s", $sampled(exp_out_test), $sampled(exp_out_s), $sampled(s));

    chk_cout: assert property (@(posedge clk)
        (check_en && exp_out_valid) |-> (cout == exp_out_cout))
        else report_mismatch("cout", $sampled(exp_out_test), word_t'($sampled(exp_out_cout)),
                             word_t'($sampled(cout)));

    chk_sat: assert property (@(posedge clk)
        (check_en && exp_out_valid) |-> (sat == exp_out_sat))
        else report_mismatch("sat", $sampled(exp_out_test), word_t'($sampled(exp_out_sat)),
                             word_t'($sampled(sat)));

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        padd         = 1'b0;
        sub          = 1'b0;
        a            = '0;
        b            = '0;
        exp_in_s     = '0;      // zero inputs give a zero result
        exp_in_cout  = 1'b0;
        exp_in_sat   = 1'b0;
        exp_in_valid = 1'b1;
        exp_in_test  = 0;
        check_en     = 1'b0;
        rng_state    = 32'd26;
        mismatches   = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            test_errs[t] = 0;
        @(posedge clk);
        check_en <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_n <= 1'b1;          // first edge after release still sees zero inputs
        drain_pipe();
        finish_test(0, 1);
        run_tests();
        $display("summary: %0d tests ok, %0d tests with errors, %0d mismatches",
                 tests_ok, tests_bad, mismatches);
        if (mismatches == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

//--- verilog/adder_cla_4bit.sv
/*
 * 4-bit carry-lookahead adder slice
 * sum, signed overflow, and group propagate/generate
 * for the second lookahead level
 */
`timescale 1ns/100ps

module adder_cla_4bit (
    input  addsub_pkg::nib_t a,     // lane operand a
    input  addsub_pkg::nib_t b,     // lane operand b, already conditioned
    input  logic             cin,   // lane carry-in
    output addsub_pkg::nib_t s,     // raw sum, not saturated
    output logic             ovfl,  // signed overflow of this lane
    output logic             prop_group,
    output logic             gen_group
);
    import addsub_pkg::*;

    nib_t p;    // bit propagate
    nib_t g;    // bit generate
    nib_t c;    // carry into each bit

    assign p = a ^ b;
    assign g = a & b;

    // carries straight from p/g and cin, no ripple
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2]
                | (p[2] & g[1])
                | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);

    assign s = p ^ c;

    // same operand signs but sum sign flipped
    assign ovfl = (a[3] ~^ b[3]) & (s[3] ^ a[3]);

    // group terms, independent of cin so no loop through the lookahead
    assign prop_group = &p;                 // carry passes through all 4 bits
    assign gen_group  = g[3]
                      | (p[3] & g[2])
                      | (p[3] & p[2] & g[1])
                      | (p[3] & p[2] & p[1] & g[0]);   // carry made inside slice

endmodule

//--- verilog/addsub_16bit.sv
/*
 * combinational core of the saturating adder/subtractor
 * lookahead feeder, four cla slices in a generate loop,
 * saturation drain
 */
`timescale 1ns/100ps

`include "addsub_params.svh"

module addsub_16bit (
    input  logic              padd,   // 1: four 4-bit lanes
    input  logic              sub,    // 1: a - b
    input  addsub_pkg::word_t a,      // operand a
    input  addsub_pkg::word_t b,      // operand b
    output addsub_pkg::word_t s,      // saturated result
    output logic              cout,   // carry-out, whole-word only
    output logic              sat     // some lane or the word clamped
);
    import addsub_pkg::*;

    word_t      b_cond;     // b after optional inversion
    word_t      raw_sum;    // slice sums before clamping
    lane_bits_t lane_cin;   // carry into each slice
    lane_bits_t ovfl;       // overflow out of each slice
    lane_bits_t prop;       // group propagate
    lane_bits_t gen;        // group generate

    // b conditioning + lane carries
    operand_lookahead operand_lookahead_inst (
        .padd     (padd),
        .sub      (sub),
        .b        (b),
        .prop     (prop),
        .gen      (gen),
        .b_cond   (b_cond),
        .lane_cin (lane_cin),
        .cout     (cout)
    );

    // one slice per lane
    // p/g only depend on a and b_cond, so feeding them back is loop free
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_slice
        adder_cla_4bit adder_cla_4bit_inst (
            .a          (a[i*`LANE_WIDTH +: `LANE_WIDTH]),
            .b          (b_cond[i*`LANE_WIDTH +: `LANE_WIDTH]),
            .cin        (lane_cin[i]),
            .s          (raw_sum[i*`LANE_WIDTH +: `LANE_WIDTH]),
            .ovfl       (ovfl[i]),
            .prop_group (prop[i]),
            .gen_group  (gen[i])
        );
    end

    // clamp and flag
    saturate_unit saturate_unit_inst (
        .padd    (padd),
        .raw_sum (raw_sum),
        .ovfl    (ovfl),
        .s       (s),
        .sat     (sat)
    );

endmodule

//--- verilog/addsub_params.svh
/*
 * width macros for the 16-bit saturating adder/subtractor
 * word width, lane width and lane count of the cla slices
 * signed saturation limits for one lane and for the whole word
 */
`ifndef ADDSUB_PARAMS_SVH
`define ADDSUB_PARAMS_SVH

// data word, split into equal lanes
`define ADDSUB_WIDTH 16
`define LANE_WIDTH 4            // one cla slice
`define NUM_LANES 4             // ADDSUB_WIDTH / LANE_WIDTH

// clamp values, packed mode (per 4-bit lane)
`define ADDSUB_LANE_MAX 4'h7    // +7
`define ADDSUB_LANE_MIN 4'h8    // -8

// clamp values, whole-word mode
`define ADDSUB_WORD_MAX 16'h7FFF
`define ADDSUB_WORD_MIN 16'h8000

// a lane clamp and a word clamp must agree on the sign bit position
// so LANE_WIDTH * NUM_LANES has to stay equal to ADDSUB_WIDTH

`endif

//--- verilog/addsub_pkg.sv
/*
 * shared vector types for the saturating adder/subtractor datapath
 * word_t for operands and results, nib_t for one lane,
 * lane_bits_t for per-lane carry, overflow, propagate and generate
 */
package addsub_pkg;

`include "addsub_params.svh"

    // full operand / result word
    typedef logic [`ADDSUB_WIDTH-1:0] word_t;

    // one lane of a word, also the width of a cla slice
    typedef logic [`LANE_WIDTH-1:0] nib_t;

    // one bit per lane
    // used for lane carry-ins, overflow flags and the
    // group propagate / generate vectors between the slices
    // and the second-level lookahead
    typedef logic [`NUM_LANES-1:0] lane_bits_t;

    // nib_t and lane_bits_t are both 4 bits wide only because
    // the lane count happens to equal the lane width

endpackage

//--- verilog/addsub_stage.sv
/*
 * top level of the saturating adder/subtractor
 * combinational core plus one output register stage
 * async active-low clear, output assertions
 */
`timescale 1ns/100ps

`include "addsub_params.svh"

module addsub_stage (
    input  logic              clk,
    input  logic              rst_n,  // async clear, active low
    input  logic              padd,   // packed mode, sampled every edge
    input  logic              sub,    // subtract
    input  addsub_pkg::word_t a,
    input  addsub_pkg::word_t b,
    output addsub_pkg::word_t s,      // result, one cycle after inputs
    output logic              cout,
    output logic              sat
);
    import addsub_pkg::*;

    word_t      s_core;         // core result, unregistered
    logic       cout_core;
    logic       sat_core;
    lane_bits_t lane_at_limit;  // registered lane sits on +7 or -8

    addsub_16bit addsub_16bit_inst (
        .padd (padd),
        .sub  (sub),
        .a    (a),
        .b    (b),
        .s    (s_core),
        .cout (cout_core),
        .sat  (sat_core)
    );

    // single pipeline stage, new op accepted every clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s    <= '0;
            cout <= 1'b0;
            sat  <= 1'b0;
        end else begin
            s    <= s_core;
            cout <= cout_core;
            sat  <= sat_core;
        end
    end

    // per-lane limit check on the registered result
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_limit
        assign lane_at_limit[i] =
            (s[i*`LANE_WIDTH +: `LANE_WIDTH] == `ADDSUB_LANE_MAX) ||
            (s[i*`LANE_WIDTH +: `LANE_WIDTH] == `ADDSUB_LANE_MIN);
    end

    // packed op never leaves a carry behind
    a_padd_no_cout: assert property (@(posedge clk) disable iff (!rst_n)
        padd |=> !cout)
        else $error("cout set after a packed operation");

    // async clear holds all outputs at zero
    a_reset_clear: assert property (@(posedge clk)
        !rst_n |-> (s == '0) && !cout && !sat)
        else $error("outputs not cleared during reset");

    // flag only with a clamp value, checked against the mode of the previous edge
    a_sat_value: assert property (@(posedge clk) disable iff (!rst_n)
        sat |-> ($past(padd) ? (|lane_at_limit)
                             : ((s == `ADDSUB_WORD_MAX) || (s == `ADDSUB_WORD_MIN))))
        else $error("sat set but s = %h is not a saturation value", s);

endmodule

//--- verilog/operand_lookahead.sv
/*
 * operand b conditioning and second-level carry lookahead
 * drives the conditioned b and each slice's carry-in,
 * breaks the carry chain in packed mode
 */
`timescale 1ns/100ps

`include "addsub_params.svh"

module operand_lookahead (
    input  logic                   padd,     // packed 4x4-bit mode
    input  logic                   sub,      // subtract
    input  addsub_pkg::word_t      b,        // raw operand b
    input  addsub_pkg::lane_bits_t prop,     // group propagate from slices
    input  addsub_pkg::lane_bits_t gen,      // group generate from slices
    output addsub_pkg::word_t      b_cond,   // b or ~b
    output addsub_pkg::lane_bits_t lane_cin, // carry-in per slice
    output logic                   cout      // word carry-out
);
    import addsub_pkg::*;

    lane_bits_t chain_cin;  // whole-word carries into lanes
    logic       chain_cout; // whole-word carry out of lane 3

    // one's complement only with the +1 entering as carry-in
    assign b_cond = sub ? ~b : b;

    // lane carries from group p/g flattened per lane
    assign chain_cin[0] = sub;
    assign chain_cin[1] = gen[0] | (prop[0] & sub);
    assign chain_cin[2] = gen[1]
                        | (prop[1] & gen[0])
                        | (prop[1] & prop[0] & sub);
    assign chain_cin[3] = gen[2]
                        | (prop[2] & gen[1])
                        | (prop[2] & prop[1] & gen[0])
                        | (prop[2] & prop[1] & prop[0] & sub);

    // same form one lane further up
    assign chain_cout = gen[3]
                      | (prop[3] & gen[2])
                      | (prop[3] & prop[2] & gen[1])
                      | (prop[3] & prop[2] & prop[1] & gen[0])
                      | (prop[3] & prop[2] & prop[1] & prop[0] & sub);

    // in packed mode every lane starts fresh with sub as its +1
    assign lane_cin = padd ? {`NUM_LANES{sub}} : chain_cin;

    // no meaningful carry-out across independent lanes
    assign cout = padd ? 1'b0 : chain_cout;

endmodule

//--- verilog/saturate_unit.sv
/*
 * signed saturation of the raw slice sums
 * packed mode clamps each lane on its own overflow bit,
 * whole-word mode clamps the word on lane 3 overflow
 * also raises sat when any clamp was applied
 */
`timescale 1ns/100ps

`include "addsub_params.svh"

module saturate_unit (
    input  logic                   padd,    // packed mode select
    input  addsub_pkg::word_t      raw_sum, // concatenated slice sums
    input  addsub_pkg::lane_bits_t ovfl,    // per-lane signed overflow
    output addsub_pkg::word_t      s,       // saturated result
    output logic                   sat      // a clamp happened
);
    import addsub_pkg::*;

    word_t packed_s;    // per-lane clamped result
    word_t word_s;      // whole-word clamped result
    word_t word_clamp;  // limit picked for the whole word
    logic  word_ovfl;   // only the top lane counts for the full word

    // packed lanes, each one handled alone
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        nib_t lane_raw;
        nib_t lane_clamp;

        assign lane_raw = raw_sum[i*`LANE_WIDTH +: `LANE_WIDTH];

        // on overflow the raw sign is the wrong one
        // raw negative means the true result was too large
        assign lane_clamp = lane_raw[`LANE_WIDTH-1] ? `ADDSUB_LANE_MAX
                                                    : `ADDSUB_LANE_MIN;

        assign packed_s[i*`LANE_WIDTH +: `LANE_WIDTH] =
            ovfl[i] ? lane_clamp : lane_raw;
    end

    // whole word, same rule on the word msb
    assign word_ovfl  = ovfl[`NUM_LANES-1];
    assign word_clamp = raw_sum[`ADDSUB_WIDTH-1] ? `ADDSUB_WORD_MAX
                                                 : `ADDSUB_WORD_MIN;
    assign word_s     = word_ovfl ? word_clamp : raw_sum;

    // lower lane overflows are carries inside the word, ignored here
    assign s   = padd ? packed_s : word_s;
    assign sat = padd ? |ovfl : word_ovfl;

endmodule
